/* source/uart_mem_pkg.sv */
package uart_mem_pkg;

    // uart bit time in clk1 cycles
    localparam int clks_per_bit = 16;

    // memory geometry, one address byte per frame
    localparam int addr_bits = 8;
    localparam int mem_words = 256;

    // frame command bytes, ascii W and R
    localparam logic [7:0] cmd_write_code = 8'h57;
    localparam logic [7:0] cmd_read_code  = 8'h52;

    // bytes per data word on the serial link
    localparam int word_bytes = 4;

    // buffer depths
    localparam int cmd_fifo_depth = 4;
    localparam int tx_fifo_depth  = 8;

    typedef logic [7:0]           byte_t;
    typedef logic [31:0]          word_t;
    typedef logic [addr_bits-1:0] addr_t;

    // one memory command, 41 bits
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t data;
    } mem_cmd_t;

endpackage

/* source/wb_if.sv */
`timescale 1ns/1ps

interface wb_if;
    import uart_mem_pkg::*;

    // cycle control
    logic  cyc;
    logic  stb;
    logic  we;
    // address and data
    addr_t adr;
    word_t dat_w;
    word_t dat_r;
    // slave handshake
    logic  ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                clk1,
    input  logic                rst_n,
    input  logic                rxd,
    output uart_mem_pkg::byte_t rx_byte,
    output logic                byte_valid
);
    import uart_mem_pkg::*;

    typedef logic [$clog2(clks_per_bit)-1:0] tick_t;
    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    tick_t      clk_cnt;
    logic [2:0] bit_idx;
    // two-flop synchronizer, idles high
    logic       rxd_meta;
    logic       rxd_sync;

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // bit timing and framing
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            state      <= st_idle;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    // falling edge of start bit
                    clk_cnt <= '0;
                    if (!rxd_sync) state <= st_start;
                end
                st_start: begin
                    // half a bit to reach the middle
                    if (clk_cnt == tick_t'(clks_per_bit / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch, line went back high
                        state   <= rxd_sync ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (clk_cnt == tick_t'(clks_per_bit - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    // middle of stop bit, low stop means framing error
                    if (clk_cnt == tick_t'(clks_per_bit - 1)) begin
                        byte_valid <= rxd_sync;
                        state      <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first shift at each data bit center
    always_ff @(posedge clk1) begin
        if (state == st_data && clk_cnt == tick_t'(clks_per_bit - 1)) begin
            rx_byte <= {rxd_sync, rx_byte[7:1]};
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                clk1,
    input  logic                rst_n,
    input  logic                tx_empty,
    input  uart_mem_pkg::byte_t tx_head,
    output logic                tx_pop,
    output logic                txd
);
    import uart_mem_pkg::*;

    typedef logic [$clog2(clks_per_bit)-1:0] tick_t;

    logic       busy;
    tick_t      clk_cnt;
    logic [3:0] bit_num;
    // stop, data, start; bit 0 goes on the line
    logic [9:0] shift_reg;

    // take the head byte as soon as the line is free
    assign tx_pop = !busy && !tx_empty;
    assign txd    = shift_reg[0];

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_num   <= '0;
            shift_reg <= '1;
        end else if (tx_pop) begin
            busy      <= 1'b1;
            clk_cnt   <= '0;
            bit_num   <= '0;
            shift_reg <= {1'b1, tx_head, 1'b0};
        end else if (busy) begin
            if (clk_cnt == tick_t'(clks_per_bit - 1)) begin
                clk_cnt   <= '0;
                // fill with ones so the line idles high
                shift_reg <= {1'b1, shift_reg[9:1]};
                bit_num   <= bit_num + 1'b1;
                if (bit_num == 4'd9) busy <= 1'b0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser (
    input  logic                   clk1,
    input  logic                   rst_n,
    input  uart_mem_pkg::byte_t    rx_byte,
    input  logic                   byte_valid,
    input  logic                   cmd_full,
    output logic                   cmd_push,
    output uart_mem_pkg::mem_cmd_t cmd_out
);
    import uart_mem_pkg::*;

    typedef enum logic [1:0] {st_cmd, st_addr, st_data} state_t;

    state_t     state;
    logic       is_write;
    logic [1:0] byte_cnt;
    addr_t      addr_q;
    word_t      data_q;
    logic       frame_done;

    // last byte of a frame, read ends at address, write at fourth data byte
    assign frame_done = byte_valid &&
                        ((state == st_addr && !is_write) ||
                         (state == st_data && byte_cnt == 2'(word_bytes - 1)));

    assign cmd_out = '{write: is_write, addr: addr_q, data: data_q};

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            state    <= st_cmd;
            is_write <= 1'b0;
            byte_cnt <= '0;
            cmd_push <= 1'b0;
        end else begin
            // frame dropped when buffer is full
            cmd_push <= frame_done && !cmd_full;
            if (byte_valid) begin
                case (state)
                    st_cmd: begin
                        // unknown bytes keep us here
                        if (rx_byte == cmd_write_code || rx_byte == cmd_read_code) begin
                            is_write <= (rx_byte == cmd_write_code);
                            state    <= st_addr;
                        end
                    end
                    st_addr: begin
                        byte_cnt <= '0;
                        state    <= is_write ? st_data : st_cmd;
                    end
                    default: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (frame_done) state <= st_cmd;
                    end
                endcase
            end
        end
    end

    // address and word assembly, msb first
    always_ff @(posedge clk1) begin
        if (byte_valid && state == st_addr) addr_q <= rx_byte;
        if (byte_valid && state == st_data) data_q <= {data_q[23:0], rx_byte};
    end

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic                       clk1,
    input  logic                       rst_n,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(depth+1)-1:0] count
);

    typedef logic [$clog2(depth)-1:0] ptr_t;

    payload_t mem [depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;

    assign full     = (count == ($clog2(depth+1))'(depth));
    assign empty    = (count == '0);
    // head entry, valid while not empty
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk1) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    // producer and consumer must respect the flags
    a_no_overflow:  assert property (@(posedge clk1) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk1) disable iff (!rst_n) pop |-> !empty);

endmodule

/* source/wb_master.sv */
`timescale 1ns/1ps

module wb_master (
    input  logic                   clk1,
    input  logic                   rst_n,
    input  logic                   cmd_empty,
    input  uart_mem_pkg::mem_cmd_t cmd_head,
    output logic                   cmd_pop,
    input  logic [$clog2(uart_mem_pkg::tx_fifo_depth+1)-1:0] tx_count,
    output logic                   tx_push,
    output uart_mem_pkg::byte_t    tx_byte,
    wb_if.master                   bus
);
    import uart_mem_pkg::*;

    typedef enum logic [1:0] {st_idle, st_bus, st_push} state_t;

    state_t     state;
    logic [1:0] byte_cnt;
    mem_cmd_t   cmd_q;
    word_t      word_q;
    logic       start_access;

    // reads wait for room for a whole reply word
    assign start_access = (state == st_idle) && !cmd_empty &&
                          (cmd_head.write || int'(tx_count) <= tx_fifo_depth - word_bytes);
    assign cmd_pop = start_access;

    ////////////////////////////////////////////////////////////
    // wishbone classic, signals held from captured command
    ////////////////////////////////////////////////////////////
    assign bus.cyc   = (state == st_bus);
    assign bus.stb   = (state == st_bus);
    assign bus.we    = cmd_q.write;
    assign bus.adr   = cmd_q.addr;
    assign bus.dat_w = cmd_q.data;

    // reply bytes, msb first
    assign tx_push = (state == st_push);
    assign tx_byte = word_q[31:24];

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            state    <= st_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                st_idle: if (start_access) state <= st_bus;
                st_bus: begin
                    byte_cnt <= '0;
                    if (bus.ack) state <= cmd_q.write ? st_idle : st_push;
                end
                default: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'(word_bytes - 1)) state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk1) begin
        if (start_access) cmd_q <= cmd_head;
        // latch read word at ack, then shift out a byte per cycle
        if (state == st_bus && bus.ack) word_q <= bus.dat_r;
        else if (state == st_push) word_q <= {word_q[23:0], 8'h00};
    end

endmodule

/* source/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram (
    input logic  clk1,
    input logic  rst_n,
    wb_if.slave  bus
);
    import uart_mem_pkg::*;

    word_t mem [mem_words];
    logic  req;

    // new request not yet acknowledged
    assign req = bus.cyc && bus.stb && !bus.ack;

    // registered ack follows stb by one cycle
    always_ff @(posedge clk1) begin
        if (!rst_n) bus.ack <= 1'b0;
        else        bus.ack <= req;
    end

    always_ff @(posedge clk1) begin
        if (req && bus.we) mem[bus.adr] <= bus.dat_w;
        // read data lines up with ack
        if (req) bus.dat_r <= mem[bus.adr];
    end

    // master holds the request until ack
    a_req_stable: assert property (@(posedge clk1) disable iff (!rst_n)
        (bus.stb && !bus.ack) |=> (bus.stb && $stable(bus.adr) && $stable(bus.we)));

    // master ends the cycle right after ack
    a_cycle_end: assert property (@(posedge clk1) disable iff (!rst_n)
        bus.ack |=> (!bus.cyc && !bus.stb));

endmodule

/* source/uart_mem_top.sv */
`timescale 1ns/1ps

module uart_mem_top (
    input  logic clk1,
    input  logic rst_n,
    input  logic uart_rx,
    output logic uart_tx
);
    import uart_mem_pkg::*;

    // receive side
    byte_t    rx_byte;
    logic     byte_valid;
    // command buffer
    logic     cmd_push;
    mem_cmd_t cmd_wr;
    logic     cmd_full;
    logic     cmd_empty;
    mem_cmd_t cmd_head;
    logic     cmd_pop;
    // read-back buffer
    logic [$clog2(tx_fifo_depth+1)-1:0] tx_count;
    logic     tx_push;
    byte_t    tx_byte;
    logic     tx_pop;
    byte_t    tx_head;
    logic     tx_empty;

    wb_if bus ();

    ////////////////////////////////////////////////////////////
    // serial in, parse, buffer
    ////////////////////////////////////////////////////////////
    uart_rx u_uart_rx (.clk1(clk1), .rst_n(rst_n), .rxd(uart_rx),
                       .rx_byte(rx_byte), .byte_valid(byte_valid));

    cmd_parser u_cmd_parser (.clk1(clk1), .rst_n(rst_n), .rx_byte(rx_byte),
                             .byte_valid(byte_valid), .cmd_full(cmd_full),
                             .cmd_push(cmd_push), .cmd_out(cmd_wr));

    sync_fifo #(.payload_t(mem_cmd_t), .depth(cmd_fifo_depth)) cmd_fifo (
        .clk1(clk1), .rst_n(rst_n), .push(cmd_push), .push_data(cmd_wr),
        .pop(cmd_pop), .pop_data(cmd_head), .full(cmd_full), .empty(cmd_empty),
        .count());

    ////////////////////////////////////////////////////////////
    // memory access and serial reply
    ////////////////////////////////////////////////////////////
    wb_master u_wb_master (.clk1(clk1), .rst_n(rst_n), .cmd_empty(cmd_empty),
                           .cmd_head(cmd_head), .cmd_pop(cmd_pop), .tx_count(tx_count),
                           .tx_push(tx_push), .tx_byte(tx_byte), .bus(bus.master));

    wb_ram u_wb_ram (.clk1(clk1), .rst_n(rst_n), .bus(bus.slave));

    sync_fifo #(.payload_t(byte_t), .depth(tx_fifo_depth)) tx_fifo (
        .clk1(clk1), .rst_n(rst_n), .push(tx_push), .push_data(tx_byte),
        .pop(tx_pop), .pop_data(tx_head), .full(), .empty(tx_empty),
        .count(tx_count));

    uart_tx u_uart_tx (.clk1(clk1), .rst_n(rst_n), .tx_empty(tx_empty),
                       .tx_head(tx_head), .tx_pop(tx_pop), .txd(uart_tx));

endmodule

/* dv/tb_uart_mem.sv */
`timescale 1ns/1ps

module tb_uart_mem;
    import uart_mem_pkg::*;

    localparam int max_tests   = 32;
    localparam int rand_writes = 8;
    // reads in flight before the serial driver holds off
    localparam int max_pending = 3;

    logic clk1;
    logic rst_n;
    logic uart_rx;
    logic uart_tx;

    // three hex words per data file line for command, address and data
    logic [31:0] test_mem [3*max_tests];
    word_t       model [mem_words];
    word_t       expected_q [$];
    addr_t       rand_addr [rand_writes];
    int          n_tests    = 0;
    int          run_lines  = 0;
    int          reads_sent = 0;
    int          words_rcvd = 0;
    int          bytes_rcvd = 0;
    integer      seed       = 27295;

    uart_mem_top UUT (.clk1(clk1), .rst_n(rst_n), .uart_rx(uart_rx), .uart_tx(uart_tx));

    always #50 clk1 = ~clk1;

    ////////////////////////////////////////////////////////////
    // failure handling and checks
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // serial driver
    ////////////////////////////////////////////////////////////
    // start bit then 8 data bits lsb first then stop bit
    task automatic drive_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk1);
            uart_rx <= frame[i];
            repeat (clks_per_bit - 1) @(posedge clk1);
        end
    endtask

    // data word goes msb first
    task automatic write_frame(input addr_t addr, input word_t data);
        model[addr] = data;
        drive_byte(cmd_write_code);
        drive_byte(addr);
        for (int k = word_bytes - 1; k >= 0; k--) drive_byte(data[8*k +: 8]);
    endtask

    task automatic read_frame(input addr_t addr, input word_t expected);
        // no reply bytes before the first read
        if (reads_sent == 0) check_value("reply bytes before first read", 32'd0, bytes_rcvd);
        // keep the command buffer from overflowing
        while (reads_sent - words_rcvd >= max_pending) @(posedge clk1);
        expected_q.push_back(expected);
        reads_sent++;
        drive_byte(cmd_read_code);
        drive_byte(addr);
    endtask

    // address byte of an unknown frame must not look like a command
    task automatic junk_frame(input byte_t cmd, input addr_t addr);
        if (addr == cmd_write_code || addr == cmd_read_code) begin
            $display("unknown frame in data file has a command code as address");
            abort_run();
        end
        drive_byte(cmd);
        drive_byte(addr);
    endtask

    ////////////////////////////////////////////////////////////
    // reply monitor
    ////////////////////////////////////////////////////////////
    initial begin
        byte_t rx_b;
        word_t rx_word;
        rx_b    = '0;
        rx_word = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk1);
            if (uart_tx === 1'b0) begin
                // to middle of start bit
                repeat (clks_per_bit / 2) @(posedge clk1);
                if (uart_tx !== 1'b0) begin
                    $display("start bit on uart_tx was too short");
                    abort_run();
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(posedge clk1);
                    rx_b = {uart_tx, rx_b[7:1]};
                end
                repeat (clks_per_bit) @(posedge clk1);
                if (uart_tx !== 1'b1) begin
                    $display("stop bit on uart_tx was low");
                    abort_run();
                end
                bytes_rcvd++;
                rx_word = {rx_word[23:0], rx_b};
                // reply words arrive msb first
                if (bytes_rcvd % word_bytes == 0) begin
                    if (expected_q.size() == 0) begin
                        $display("reply word arrived with no read pending");
                        abort_run();
                    end else begin
                        check_value("reply word", expected_q.pop_front(), rx_word);
                        words_rcvd++;
                    end
                end
            end
        end
    end

    // watchdog scaled by the length of the run
    initial begin
        longint limit_ns;
        wait (run_lines > 0);
        limit_ns = 2 * longint'(run_lines) * 11 * 10 * clks_per_bit * 100;
        #(limit_ns);
        $display("timeout waiting for reply");
        abort_run();
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        byte_t cmd;
        addr_t addr;
        word_t data;
        clk1    = 1'b0;
        rst_n   = 1'b0;
        uart_rx = 1'b1;
        $readmemh("dv/uart_mem_tests.txt", test_mem);
        // command 00 ends the list
        while (n_tests < max_tests && test_mem[3*n_tests] != 32'h0) n_tests++;
        if (n_tests == 0) begin
            $display("no tests found in data file");
            abort_run();
        end
        run_lines = n_tests + 2 * rand_writes;

        repeat (3) @(posedge clk1);
        rst_n <= 1'b1;

        // line idles high after reset
        repeat (4 * clks_per_bit) begin
            @(posedge clk1);
            check_value("uart_tx", 32'd1, 32'(uart_tx));
        end

        // file frames sent back to back
        for (int t = 0; t < n_tests; t++) begin
            cmd  = byte_t'(test_mem[3*t]);
            addr = addr_t'(test_mem[3*t+1]);
            data = test_mem[3*t+2];
            if (cmd == cmd_write_code) write_frame(addr, data);
            else if (cmd == cmd_read_code) read_frame(addr, data);
            else junk_frame(cmd, addr);
        end

        // random words read back in reverse order
        for (int i = 0; i < rand_writes; i++) begin
            rand_addr[i] = addr_t'($random(seed));
            write_frame(rand_addr[i], word_t'($random(seed)));
        end
        for (int i = rand_writes - 1; i >= 0; i--) begin
            read_frame(rand_addr[i], model[rand_addr[i]]);
        end

        // drain replies and then watch for stray bytes
        while (words_rcvd < reads_sent) @(posedge clk1);
        repeat (20 * clks_per_bit) @(posedge clk1);
        if (bytes_rcvd != word_bytes * reads_sent) begin
            $display("reply byte count does not match the reads sent");
            abort_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* uart_mem.f */
source/uart_mem_pkg.sv
source/wb_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_parser.sv
source/sync_fifo.sv
source/wb_master.sv
source/wb_ram.sv
source/uart_mem_top.sv
dv/tb_uart_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_mem
FILELIST  ?= uart_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/uart_mem_tests.txt */
// columns: command byte (57 write, 52 read, other unknown), address byte, data word
// a read line holds the expected reply; a line with command 00 ends the list
57 10 deadbeef
52 10 deadbeef
57 10 12345678
57 11 a5a5a5a5
57 0f 0badf00d
52 10 12345678
57 20 cafef00d
57 21 00ff00ff
52 21 00ff00ff
52 20 cafef00d
52 11 a5a5a5a5
41 00 00000000
52 0f 0badf00d
00 00 00000000
